// File: hw/vision_pkg.sv
/* Vision types for the ball tracker.
   Pixel, HSV and class types, colour thresholds and overlay colours. */
`default_nettype none

package vision_pkg;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// hue in half degrees, 0 to 179
	typedef struct packed {
		logic [7:0] hue;
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	typedef enum logic [1:0] {
		CLASS_NONE,
		CLASS_RED,
		CLASS_YELLOW,
		CLASS_TEAL
	} ball_class_e;

	localparam int N_CLASSES = 3;

	typedef logic [10:0] coord_t;

	// sat and val bounds are strict, hue bounds inclusive
	localparam logic [7:0] RED_HUE_LO = 8'd6;
	localparam logic [7:0] RED_HUE_HI = 8'd170;
	localparam logic [7:0] RED_SAT_MIN = 8'd84;
	localparam logic [7:0] RED_VAL_MIN = 8'd100;
	localparam logic [7:0] YEL_HUE_LO = 8'd23;
	localparam logic [7:0] YEL_HUE_HI = 8'd32;
	localparam logic [7:0] YEL_SAT_MIN = 8'd127;
	localparam logic [7:0] YEL_VAL_MIN = 8'd124;
	localparam logic [7:0] TEAL_HUE_LO = 8'd80;
	localparam logic [7:0] TEAL_HUE_HI = 8'd100;
	localparam logic [7:0] TEAL_SAT_MIN = 8'd100;
	localparam logic [7:0] TEAL_VAL_MIN = 8'd100;

	// indexed by class minus one: red, yellow, teal
	localparam rgb_t MARKER_COL [N_CLASSES] = '{24'hff1000, 24'hffff00, 24'h008080};
	localparam rgb_t BOX_COL [N_CLASSES] = '{24'hff0000, 24'hffff00, 24'h008080};

endpackage

`default_nettype wire

// File: hw/msg_pkg.sv
/* CPU message definitions.
   Register map, block and message IDs and the message word layout. */
`default_nettype none

package msg_pkg;
	import vision_pkg::*;

	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG = 3'd1;
	localparam logic [2:0] ADDR_ID = 3'd2;

	localparam logic [31:0] BLOCK_ID = 32'h1234EEE2;
	localparam logic [31:0] MSG_ID = {8'h00, "RBB"};

	localparam int STATUS_FLUSH_BIT = 4;

	typedef struct packed {
		logic [4:0] pad_l;
		coord_t left;
		logic [4:0] pad_r;
		coord_t right;
	} msg_bounds_t;

	// first word of a message is raw, the rest are bounds
	typedef union packed {
		logic [31:0] raw;
		msg_bounds_t bounds;
	} msg_word_u;

endpackage

`default_nettype wire

// File: hw/pixel_if.sv
/* One stage of the pixel stream, ready/valid with packet markers */
`timescale 1ns/1ps
`default_nettype none

interface pixel_if import vision_pkg::*; ();

	rgb_t pixel;
	logic sop;
	logic eop;
	logic valid;
	logic ready;

	modport source (output pixel, output sop, output eop, output valid, input ready);
	modport sink (input pixel, input sop, input eop, input valid, output ready);

endinterface

`default_nettype wire

// File: hw/stream_reg.sv
/* Registered ready/valid buffer holding one video beat */
`timescale 1ns/1ps
`default_nettype none

module stream_reg import vision_pkg::*; (
	input wire clk,
	input wire reset_n,
	pixel_if.sink in,
	pixel_if.source out
);

	logic armed;
	logic full;
	rgb_t pixel_q;
	logic sop_q;
	logic eop_q;

	// stays closed for the first cycle out of reset
	assign in.ready = armed & (~full | out.ready);
	assign out.valid = full;
	assign out.pixel = pixel_q;
	assign out.sop = sop_q;
	assign out.eop = eop_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			armed <= 1'b0;
			full <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (in.ready)
				full <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid && in.ready) begin
			pixel_q <= in.pixel;
			sop_q <= in.sop;
			eop_q <= in.eop;
		end
	end

	// a stalled beat from upstream must stay put until taken
	held_beat_stable: assert property (@(posedge clk) disable iff (!reset_n)
		in.valid && !in.ready |=> in.valid && $stable(in.pixel)
			&& $stable(in.sop) && $stable(in.eop));

endmodule

`default_nettype wire

// File: hw/colour_detector.sv
/* Ball colour detector.
   HSV conversion, class decision, run filter and repainting of video pixels. */
`timescale 1ns/1ps
`default_nettype none

module colour_detector import vision_pkg::*; #(
	parameter int RUN_LEN = 10
) (
	input wire clk,
	input wire reset_n,
	pixel_if.sink in,
	pixel_if.source out,
	input wire mode,
	input wire coord_t x,
	input wire packet_video,
	input wire coord_t left [N_CLASSES],
	input wire coord_t right [N_CLASSES],
	output ball_class_e pix_class,
	output logic confirmed
);

	localparam int CW = $clog2(RUN_LEN + 1);

	hsv_t hsv;
	logic [CW-1:0] run_cnt [N_CLASSES];
	logic [7:0] grey_lvl;
	rgb_t painted;
	logic accept;

	assign accept = in.valid & in.ready;
	assign in.ready = out.ready;
	assign out.valid = in.valid;
	assign out.sop = in.sop;
	assign out.eop = in.eop;

	////////////////////
	// rgb to hsv
	////////////////////
	always_comb begin
		int r;
		int g;
		int b;
		int mx;
		int mn;
		int d;
		int h;
		r = int'(in.pixel.red);
		g = int'(in.pixel.green);
		b = int'(in.pixel.blue);
		mx = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		d = mx - mn;
		h = 0;
		if (d != 0) begin
			if (mx == r)
				h = (60 * (g - b)) / d;
			else if (mx == g)
				h = 120 + (60 * (b - r)) / d;
			else
				h = 240 + (60 * (r - g)) / d;
			// red sector wraps below zero
			if (h < 0)
				h = h + 360;
		end
		hsv.hue = 8'(h / 2);
		hsv.val = 8'(mx);
		hsv.sat = (mx == 0) ? 8'd0 : 8'((d * 255) / mx);
	end

	// red first, then yellow, then teal
	always_comb begin
		pix_class = CLASS_NONE;
		if ((hsv.hue <= RED_HUE_LO || hsv.hue >= RED_HUE_HI)
				&& hsv.sat > RED_SAT_MIN && hsv.val > RED_VAL_MIN)
			pix_class = CLASS_RED;
		else if (hsv.hue >= YEL_HUE_LO && hsv.hue <= YEL_HUE_HI
				&& hsv.sat > YEL_SAT_MIN && hsv.val > YEL_VAL_MIN)
			pix_class = CLASS_YELLOW;
		else if (hsv.hue >= TEAL_HUE_LO && hsv.hue <= TEAL_HUE_HI
				&& hsv.sat > TEAL_SAT_MIN && hsv.val > TEAL_VAL_MIN)
			pix_class = CLASS_TEAL;
	end

	////////////////////
	// run filter
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int k = 0; k < N_CLASSES; k++)
				run_cnt[k] <= '0;
		end else if (accept) begin
			for (int k = 0; k < N_CLASSES; k++) begin
				if (int'(pix_class) == k + 1)
					run_cnt[k] <= (run_cnt[k] == CW'(RUN_LEN)) ? run_cnt[k] : run_cnt[k] + 1'b1;
				else
					run_cnt[k] <= '0;
			end
		end
	end

	// green/2 + red/4 + blue/4 never exceeds 253
	assign grey_lvl = {1'b0, in.pixel.green[7:1]} + {2'b00, in.pixel.red[7:2]}
		+ {2'b00, in.pixel.blue[7:2]};

	// box columns win over markers, markers over grey
	always_comb begin
		confirmed = 1'b0;
		painted = {grey_lvl, grey_lvl, grey_lvl};
		for (int k = 0; k < N_CLASSES; k++) begin
			if (int'(pix_class) == k + 1 && run_cnt[k] >= CW'(RUN_LEN - 1)) begin
				confirmed = 1'b1;
				painted = MARKER_COL[k];
			end
		end
		// empty boxes latch as left above right
		for (int k = 0; k < N_CLASSES; k++)
			if (left[k] <= right[k] && (x == left[k] || x == right[k]))
				painted = BOX_COL[k];
	end

	// packet descriptor and non-video data go through as they are
	assign out.pixel = (mode && !in.sop && packet_video) ? painted : in.pixel;

endmodule

`default_nettype wire

// File: hw/box_tracker.sv
/* Frame position and bounding box tracker.
   Counts pixel coordinates, finds per-class column bounds and paces messages. */
`timescale 1ns/1ps
`default_nettype none

module box_tracker import vision_pkg::*; #(
	parameter int IMAGE_W = 640,
	parameter int HORIZON_ROW = 280,
	parameter int MSG_INTERVAL = 6
) (
	input wire clk,
	input wire reset_n,
	input wire accept,
	input wire sop,
	input wire eop,
	input wire [3:0] type_nibble,
	input wire ball_class_e pix_class,
	input wire confirmed,
	output coord_t x,
	output logic packet_video,
	output coord_t left [N_CLASSES],
	output coord_t right [N_CLASSES],
	output logic msg_start
);

	localparam int FW = $clog2(MSG_INTERVAL + 1);
	localparam coord_t X_LAST = coord_t'(IMAGE_W - 1);

	coord_t y;
	coord_t x_min [N_CLASSES];
	coord_t x_max [N_CLASSES];
	coord_t min_nxt [N_CLASSES];
	coord_t max_nxt [N_CLASSES];
	logic [FW-1:0] frame_cnt;
	logic frame_end;

	assign frame_end = accept & eop & packet_video;

	// packet type comes from the low nibble of the descriptor
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
		end else if (accept) begin
			if (sop) begin
				x <= '0;
				y <= '0;
				packet_video <= (type_nibble == 4'h0);
			end else if (x == X_LAST) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// bounds including the current pixel, so eop pixels also count
	always_comb begin
		for (int k = 0; k < N_CLASSES; k++) begin
			min_nxt[k] = x_min[k];
			max_nxt[k] = x_max[k];
			if (confirmed && int'(pix_class) == k + 1 && packet_video
					&& y > coord_t'(HORIZON_ROW)) begin
				if (x < x_min[k])
					min_nxt[k] = x;
				if (x > x_max[k])
					max_nxt[k] = x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int k = 0; k < N_CLASSES; k++) begin
				x_min[k] <= sop ? X_LAST : min_nxt[k];
				x_max[k] <= sop ? coord_t'(0) : max_nxt[k];
			end
		end
	end

	////////////////////
	// end of frame
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int k = 0; k < N_CLASSES; k++) begin
				left[k] <= X_LAST;
				right[k] <= '0;
			end
			frame_cnt <= '0;
			msg_start <= 1'b0;
		end else begin
			msg_start <= 1'b0;
			if (frame_end) begin
				for (int k = 0; k < N_CLASSES; k++) begin
					left[k] <= min_nxt[k];
					right[k] <= max_nxt[k];
				end
				if (frame_cnt == '0) begin
					msg_start <= 1'b1;
					frame_cnt <= FW'(MSG_INTERVAL - 1);
				end else begin
					frame_cnt <= frame_cnt - 1'b1;
				end
			end
		end
	end

	// line length from the stream has to match IMAGE_W
	x_in_line: assert property (@(posedge clk) disable iff (!reset_n)
		frame_end |-> x == X_LAST);

endmodule

`default_nettype wire

// File: hw/msg_queue.sv
/* Message writer and message FIFO.
   Queues an ID word and one bounds word per class when there is room. */
`timescale 1ns/1ps
`default_nettype none

module msg_queue import vision_pkg::*; import msg_pkg::*; #(
	parameter int FIFO_DEPTH = 256
) (
	input wire clk,
	input wire reset_n,
	input wire msg_start,
	input wire coord_t left [N_CLASSES],
	input wire coord_t right [N_CLASSES],
	input wire pop,
	input wire flush,
	output msg_word_u head,
	output logic [15:0] fifo_count,
	output logic empty
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam int MSG_WORDS = 1 + N_CLASSES;
	localparam int IW = $clog2(MSG_WORDS);

	msg_word_u mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [IW-1:0] wr_idx;
	logic busy;
	logic push;
	logic full;
	msg_word_u word;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push = busy;
	assign full = (count == CW'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign head = mem[rd_ptr];
	assign fifo_count = 16'(count);

	// whole message or nothing
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			wr_idx <= '0;
		end else if (busy) begin
			wr_idx <= wr_idx + 1'b1;
			if (wr_idx == IW'(N_CLASSES))
				busy <= 1'b0;
		end else if (msg_start && count <= CW'(FIFO_DEPTH - MSG_WORDS)) begin
			busy <= 1'b1;
			wr_idx <= '0;
		end
	end

	// word 0 is the ID, word k carries class k-1
	always_comb begin
		word.raw = MSG_ID;
		if (wr_idx != '0) begin
			word.bounds.pad_l = '0;
			word.bounds.left = left[wr_idx - 1'b1];
			word.bounds.pad_r = '0;
			word.bounds.right = right[wr_idx - 1'b1];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= word;
	end

	no_push_full: assert property (@(posedge clk) disable iff (!reset_n) push |-> !full);
	no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n) pop |-> !empty);

endmodule

`default_nettype wire

// File: hw/cpu_regs.sv
/* Memory-mapped CPU port with status, message and ID registers */
`timescale 1ns/1ps
`default_nettype none

module cpu_regs import msg_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire chipselect,
	input wire read,
	input wire write,
	input wire [2:0] address,
	input wire [31:0] writedata,
	output logic [31:0] readdata,
	input wire [15:0] fifo_count,
	input wire msg_word_u head,
	input wire empty,
	output logic pop,
	output logic flush
);

	logic [7:0] reg_status;
	logic read_d;
	logic wr_status;

	assign wr_status = chipselect & write & (address == ADDR_STATUS);
	assign flush = wr_status & writedata[STATUS_FLUSH_BIT];
	// one pop per read, however long read stays high
	assign pop = chipselect & read & ~read_d & ~empty & (address == ADDR_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n)
			reg_status <= '0;
		else if (wr_status)
			reg_status <= writedata[7:0] & ~(8'h01 << STATUS_FLUSH_BIT);
	end

	// status layout: 31:24 zero, 23:8 word count, 7:0 status byte
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= chipselect & read;
			if (chipselect && read) begin
				case (address)
					ADDR_STATUS: readdata <= {8'h00, fifo_count, reg_status};
					ADDR_MSG: readdata <= head.raw;
					ADDR_ID: readdata <= BLOCK_ID;
					default: readdata <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/ball_vision_top.sv
/* Ball tracking video block.
   Joins the stream buffers, colour detector, box tracker, message queue and CPU port. */
`timescale 1ns/1ps
`default_nettype none

module ball_vision_top import vision_pkg::*; import msg_pkg::*; #(
	parameter int IMAGE_W = 640,
	parameter int HORIZON_ROW = 280,
	parameter int RUN_LEN = 10,
	parameter int MSG_INTERVAL = 6,
	parameter int FIFO_DEPTH = 256
) (
	input wire clk,
	input wire reset_n,
	input wire s_chipselect,
	input wire s_read,
	input wire s_write,
	output logic [31:0] s_readdata,
	input wire [31:0] s_writedata,
	input wire [2:0] s_address,
	input wire [23:0] sink_data,
	input wire sink_valid,
	output logic sink_ready,
	input wire sink_sop,
	input wire sink_eop,
	output logic [23:0] source_data,
	output logic source_valid,
	input wire source_ready,
	output logic source_sop,
	output logic source_eop,
	input wire mode
);

	pixel_if sink_bus ();
	pixel_if det_bus ();
	pixel_if paint_bus ();
	pixel_if source_bus ();

	coord_t x;
	coord_t left [N_CLASSES];
	coord_t right [N_CLASSES];
	logic packet_video;
	ball_class_e pix_class;
	logic confirmed;
	logic accept;
	logic msg_start;
	msg_word_u head;
	logic [15:0] fifo_count;
	logic empty;
	logic pop;
	logic flush;

	////////////////////
	// stream ports
	////////////////////
	assign sink_bus.pixel = sink_data;
	assign sink_bus.sop = sink_sop;
	assign sink_bus.eop = sink_eop;
	assign sink_bus.valid = sink_valid;
	assign sink_ready = sink_bus.ready;

	assign source_data = source_bus.pixel;
	assign source_sop = source_bus.sop;
	assign source_eop = source_bus.eop;
	assign source_valid = source_bus.valid;
	assign source_bus.ready = source_ready;

	assign accept = det_bus.valid & det_bus.ready;

	stream_reg in_buf (
		.clk(clk),
		.reset_n(reset_n),
		.in(sink_bus),
		.out(det_bus)
	);

	colour_detector #(.RUN_LEN(RUN_LEN)) detector (
		.clk(clk),
		.reset_n(reset_n),
		.in(det_bus),
		.out(paint_bus),
		.mode(mode),
		.x(x),
		.packet_video(packet_video),
		.left(left),
		.right(right),
		.pix_class(pix_class),
		.confirmed(confirmed)
	);

	stream_reg out_buf (
		.clk(clk),
		.reset_n(reset_n),
		.in(paint_bus),
		.out(source_bus)
	);

	box_tracker #(
		.IMAGE_W(IMAGE_W),
		.HORIZON_ROW(HORIZON_ROW),
		.MSG_INTERVAL(MSG_INTERVAL)
	) tracker (
		.clk(clk),
		.reset_n(reset_n),
		.accept(accept),
		.sop(det_bus.sop),
		.eop(det_bus.eop),
		.type_nibble(det_bus.pixel.blue[3:0]),
		.pix_class(pix_class),
		.confirmed(confirmed),
		.x(x),
		.packet_video(packet_video),
		.left(left),
		.right(right),
		.msg_start(msg_start)
	);

	msg_queue #(.FIFO_DEPTH(FIFO_DEPTH)) queue (
		.clk(clk),
		.reset_n(reset_n),
		.msg_start(msg_start),
		.left(left),
		.right(right),
		.pop(pop),
		.flush(flush),
		.head(head),
		.fifo_count(fifo_count),
		.empty(empty)
	);

	cpu_regs regs (
		.clk(clk),
		.reset_n(reset_n),
		.chipselect(s_chipselect),
		.read(s_read),
		.write(s_write),
		.address(s_address),
		.writedata(s_writedata),
		.readdata(s_readdata),
		.fifo_count(fifo_count),
		.head(head),
		.empty(empty),
		.pop(pop),
		.flush(flush)
	);

endmodule

`default_nettype wire

// File: tests/ball_vision_tb.sv
/* Testbench for the ball tracking video block.
   Sends frames, predicts the repainted stream and checks the CPU message port. */
`timescale 1ns/1ps
`default_nettype none

module ball_vision_tb import vision_pkg::*; import msg_pkg::*; ();

	localparam int W = 16;
	localparam int ROWS = 2;
	localparam int RUN = 4;

	logic clk = 1'b0;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [31:0] s_readdata;
	logic [31:0] s_writedata;
	logic [2:0] s_address;
	logic [23:0] sink_data;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	logic [23:0] source_data;
	logic source_valid;
	logic source_ready = 1'b0;
	logic source_sop;
	logic source_eop;
	logic mode;

	logic bp_on = 1'b0;
	int errors_out = 0;
	int errors_reg = 0;
	int timeouts = 0;
	// expected beats as {pixel, sop, eop}
	logic [25:0] exp_mem [0:1023];
	int wr_n = 0;
	int rd_n = 0;

	// reference model state
	int run_cnt [3];
	int col_x;
	int row_y;
	logic m_video;
	int mn_c [3];
	int mx_c [3];
	int lft [3];
	int rgt [3];

	ball_vision_top #(.IMAGE_W(W), .HORIZON_ROW(0), .RUN_LEN(RUN), .MSG_INTERVAL(1)) dut0 (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_readdata(s_readdata), .s_writedata(s_writedata), .s_address(s_address),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.sink_sop(sink_sop), .sink_eop(sink_eop),
		.source_data(source_data), .source_valid(source_valid), .source_ready(source_ready),
		.source_sop(source_sop), .source_eop(source_eop), .mode(mode)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		source_ready <= bp_on ? (($urandom % 4) != 0) : 1'b1;
		if (source_valid && source_ready)
			rd_n <= rd_n + 1;
	end

	output_matches: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && source_ready |-> rd_n < wr_n
			&& {source_data, source_sop, source_eop} == exp_mem[rd_n])
		else begin
			errors_out++;
			$display("error %0t source_data/sop/eop expected %h got %h", $time,
				exp_mem[$sampled(rd_n)], {$sampled(source_data), $sampled(source_sop),
				$sampled(source_eop)});
		end

	task automatic note_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	function automatic int class_of(input logic [23:0] p);
		case (p)
			24'hff0000: return 1;
			24'hffff00: return 2;
			24'h008080: return 3;
			default: return 0;
		endcase
	endfunction

	////////////////////
	// reference model
	////////////////////
	task automatic predict(input logic [23:0] p, input logic s, input logic e, input logic m);
		int c;
		logic conf;
		logic [23:0] o;
		logic [7:0] g;
		c = class_of(p);
		conf = (c != 0) && (run_cnt[c-1] >= RUN - 1);
		for (int k = 0; k < 3; k++)
			run_cnt[k] = (k == c - 1) ? ((run_cnt[k] < RUN) ? run_cnt[k] + 1 : RUN) : 0;
		o = p;
		if (s) begin
			m_video = (p[3:0] == 4'h0);
			col_x = 0;
			row_y = 0;
			for (int k = 0; k < 3; k++) begin
				mn_c[k] = W - 1;
				mx_c[k] = 0;
			end
		end else begin
			if (m && m_video) begin
				// half the green plus a quarter of red and blue
				g = 8'(int'(p[15:8]) / 2 + int'(p[23:16]) / 4 + int'(p[7:0]) / 4);
				o = {g, g, g};
				if (conf)
					o = MARKER_COL[c-1];
				// box columns of the previous frame
				for (int k = 0; k < 3; k++)
					if (lft[k] <= rgt[k] && (col_x == lft[k] || col_x == rgt[k]))
						o = BOX_COL[k];
			end
			if (conf && m_video && row_y > 0) begin
				if (col_x < mn_c[c-1])
					mn_c[c-1] = col_x;
				if (col_x > mx_c[c-1])
					mx_c[c-1] = col_x;
			end
			if (e && m_video) begin
				lft = mn_c;
				rgt = mx_c;
			end
			if (col_x == W - 1) begin
				col_x = 0;
				row_y++;
			end else begin
				col_x++;
			end
		end
		exp_mem[wr_n] = {o, s, e};
		wr_n++;
	endtask

	task automatic send_beat(input logic [23:0] p, input logic s, input logic e, input logic m);
		int t;
		logic taken;
		predict(p, s, e, m);
		sink_data <= p;
		sink_sop <= s;
		sink_eop <= e;
		sink_valid <= 1'b1;
		taken = 1'b0;
		t = 0;
		while (!taken && timeouts == 0) begin
			@(negedge clk);
			taken = sink_ready;
			@(posedge clk);
			t++;
			if (!taken && t > 100)
				note_timeout("sink_ready");
		end
	endtask

	function automatic logic [23:0] frame_pixel(input int kind, input int c, input int r);
		if (kind == 0) begin
			case ($urandom % 4)
				0: return 24'hff0000;
				1: return 24'hffff00;
				2: return 24'h008080;
				default: return 24'h808080;
			endcase
		end
		if (kind == 2 && r == 1 && c >= 3 && c <= 8)
			return 24'hff0000;
		return 24'h808080;
	endfunction

	// kind 0 random, 1 grey, 2 red run in row 1
	task automatic send_frame(input logic video, input int kind, input logic m);
		int t;
		mode <= m;
		send_beat(video ? 24'h808080 : 24'h00000f, 1'b1, 1'b0, m);
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < W; c++)
				send_beat(frame_pixel(kind, c, r), 1'b0, (r == ROWS - 1 && c == W - 1), m);
		sink_valid <= 1'b0;
		t = 0;
		while (rd_n != wr_n && timeouts == 0) begin
			@(posedge clk);
			t++;
			if (t > 400)
				note_timeout("the output stream to drain");
		end
	endtask

	task automatic cpu_read(input logic [2:0] a, output logic [31:0] d);
		s_chipselect <= 1'b1;
		s_read <= 1'b1;
		s_address <= a;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
		@(negedge clk);
		d = s_readdata;
		@(posedge clk);
	endtask

	task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
		reg_value: assert (got == exp)
			else begin
				errors_reg++;
				$display("error %0t %s expected %h got %h", $time, name, exp, got);
			end
	endtask

	task automatic wait_count(input int n);
		logic [31:0] d;
		int t;
		t = 0;
		cpu_read(ADDR_STATUS, d);
		while (int'(d[23:8]) != n && timeouts == 0) begin
			t++;
			if (t > 50)
				note_timeout("the message count");
			cpu_read(ADDR_STATUS, d);
		end
	endtask

	task automatic flush_queue();
		logic [31:0] d;
		s_chipselect <= 1'b1;
		s_write <= 1'b1;
		s_address <= ADDR_STATUS;
		s_writedata <= 32'h1 << STATUS_FLUSH_BIT;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write <= 1'b0;
		@(posedge clk);
		cpu_read(ADDR_STATUS, d);
		check_reg("status count", {16'h0, d[23:8]}, 32'd0);
	endtask

	function automatic logic [31:0] bounds_word(input int l, input int r);
		return {5'b0, 11'(l), 5'b0, 11'(r)};
	endfunction

	initial begin
		logic [31:0] d;
		void'($urandom(32'hd4125597));
		reset_n = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_writedata = '0;
		s_address = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		mode = 1'b0;
		for (int k = 0; k < 3; k++) begin
			run_cnt[k] = 0;
			lft[k] = W - 1;
			rgt[k] = 0;
		end
		col_x = 0;
		row_y = 0;
		m_video = 1'b0;
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		bp_on <= 1'b1;

		// pass-through, then a grey frame to clear the boxes
		send_frame(1'b1, 0, 1'b0);
		send_frame(1'b1, 1, 1'b0);
		wait_count(8);
		flush_queue();

		send_frame(1'b1, 2, 1'b1);
		wait_count(4);
		for (int i = 0; i < 4; i++) begin
			cpu_read(ADDR_MSG, d);
			case (i)
				0: check_reg("message id", d, MSG_ID);
				1: check_reg("red bounds", d, bounds_word(6, 8));
				default: check_reg("empty bounds", d, bounds_word(W - 1, 0));
			endcase
			cpu_read(ADDR_STATUS, d);
			check_reg("status count", {16'h0, d[23:8]}, 32'(3 - i));
		end

		// box columns from the red frame
		send_frame(1'b1, 1, 1'b1);
		wait_count(4);
		flush_queue();

		// non-video packet, no message expected
		send_frame(1'b0, 0, 1'b1);
		cpu_read(ADDR_STATUS, d);
		check_reg("status count", {16'h0, d[23:8]}, 32'd0);
		cpu_read(ADDR_ID, d);
		check_reg("block id", d, BLOCK_ID);

		$display("errors: %0d output, %0d register, %0d timeout", errors_out, errors_reg,
			timeouts);
		if (errors_out + errors_reg + timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hw/vision_pkg.sv
hw/msg_pkg.sv
hw/pixel_if.sv
hw/stream_reg.sv
hw/colour_detector.sv
hw/box_tracker.sv
hw/msg_queue.sv
hw/cpu_regs.sv
hw/ball_vision_top.sv
tests/ball_vision_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ball vision testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module ball_vision_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vball_vision_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
	exit 0
fi
exit 1
